/* dv/alert_vectors.txt */
# W addr data | R addr expected | S channel data level, all hex
# Levels: 0 normal, 1 warning, 2 critical
S 0 1234 0
S 1 0000 0
S 2 FFFF 0
S 3 8000 0
W 0 0200
W 1 0E00
W 2 0100
W 3 0F00
R 0 0200
R 1 0E00
R 2 0100
R 3 0F00
W 4 2000
W 5 8000
W 6 1000
W 7 9000
R 5 8000
R 7 9000
S 0 00FF 2
S 0 0100 1
S 0 0180 1
S 0 0200 0
S 0 0800 0
S 0 0E00 0
S 0 0E01 1
S 0 0F00 1
S 0 0F01 2
S 1 0500 2
S 0 0300 0
S 1 1800 1
S 0 0E80 1
S 1 A000 2
S 0 0050 2
S 1 5000 0
S 2 0000 0
W D 4000
R D 4000
S 3 5000 1
S 3 1000 0
S 0 0800 0

/* dv/tb_sensor_alert.sv */
// Self-checking testbench that replays the alert vector file against the sensor alert monitor
`timescale 1ns/1ns
`default_nettype none
`include "alert_settings.svh"

module tb_sensor_alert
    import alert_pkg::*;
();

    localparam int LATENCY    = 6;
    localparam int WAIT_LIMIT = 50;

    logic                       clk;
    logic                       rst;
    logic                       sample_valid;
    chan_t                      sample_channel;
    sample_t                    sample_data;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    reg_addr_t                  wb_adr;
    sample_t                    wb_dat_w;
    sample_t                    wb_dat_r;
    logic                       wb_ack;
    logic                       result_valid;
    chan_t                      result_channel;
    level_t                     result_level;
    level_t [`ALERT_NUM_CH-1:0] alert_levels;
    level_t                     worst_level;

    // Samples in flight with the oldest at the front
    chan_t  exp_ch_q[$];
    level_t exp_lvl_q[$];
    int     entry_q[$];

    // Expected latest level of every channel
    level_t model_lv [`ALERT_NUM_CH];
    int     cycle_cnt = 0;

    // Channel of the previous sample, none yet
    int     last_ch = -1;

    sensor_alert_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .result_valid   (result_valid),
        .result_channel (result_channel),
        .result_level   (result_level),
        .alert_levels   (alert_levels),
        .worst_level    (worst_level)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR: %s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic level_t worst_of_model();
        level_t w;
        w = LVL_NORMAL;
        for (int i = 0; i < `ALERT_NUM_CH; i++) begin
            if (model_lv[i] > w) begin
                w = model_lv[i];
            end
        end
        return w;
    endfunction

    task automatic check_model();
        for (int i = 0; i < `ALERT_NUM_CH; i++) begin
            check_equal($sformatf("alert_levels[%0d]", i), model_lv[i], alert_levels[i]);
        end
        check_equal("worst_level", worst_of_model(), worst_level);
    endtask

    // Results arrive one per sample in entry order
    task automatic check_result();
        chan_t  ch;
        level_t lvl;
        int     entry;
        assert (exp_ch_q.size() > 0) else begin
            stop_with_error("result_valid rose while no sample was in flight");
        end
        ch    = exp_ch_q.pop_front();
        lvl   = exp_lvl_q.pop_front();
        entry = entry_q.pop_front();
        check_equal("result latency", LATENCY, cycle_cnt - entry);
        check_equal("result_channel", ch, result_channel);
        check_equal("result_level", lvl, result_level);
        model_lv[ch] = lvl;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (result_valid) begin
                check_result();
            end
            check_model();
        end
    end

    // Single Wishbone classic access with ack expected one cycle after the strobe
    task automatic wb_access(input logic we, input reg_addr_t adr, input sample_t wdat,
                             output sample_t rdat);
        int cnt;
        @(negedge clk);
        sample_valid = 1'b0;
        wb_cyc       = 1'b1;
        wb_stb       = 1'b1;
        wb_we        = we;
        wb_adr       = adr;
        wb_dat_w     = wdat;
        cnt = 0;
        while (!wb_ack && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt = cnt + 1;
        end
        if (!wb_ack) begin
            stop_with_error("wb_ack never came for a Wishbone access");
        end
        check_equal("wb_ack latency", 1, cnt);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_equal("wb_ack single cycle", 0, wb_ack);
    endtask

    // Zero to three idle cycles, then one sample
    // A change of channel gets no gap so alternating samples enter back to back
    task automatic send_sample(input chan_t ch, input sample_t data, input level_t lvl);
        int gap;
        gap = (int'(ch) == last_ch) ? int'($urandom % 4) : 0;
        repeat (gap) begin
            @(negedge clk);
            sample_valid = 1'b0;
        end
        @(negedge clk);
        sample_valid   = 1'b1;
        sample_channel = ch;
        sample_data    = data;
        exp_ch_q.push_back(ch);
        exp_lvl_q.push_back(lvl);
        entry_q.push_back(cycle_cnt);
        last_ch = int'(ch);
    endtask

    initial begin : stimulus
        int                 fd;
        int                 n;
        int                 cnt;
        logic [7:0]         kind;
        logic [8*128-1:0]   line;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        c;
        sample_t            rdat;
        sample_t            exp_rst;
        void'($urandom(82083));
        rst            = 1'b1;
        sample_valid   = 1'b0;
        sample_channel = '0;
        sample_data    = '0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        for (int i = 0; i < `ALERT_NUM_CH; i++) begin
            model_lv[i] = LVL_NORMAL;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_equal("wb_ack after reset", 0, wb_ack);
        check_equal("result_valid after reset", 0, result_valid);

        // Low thresholds reset to zero, high ones to all ones
        for (int ch = 0; ch < `ALERT_NUM_CH; ch++) begin
            for (int idx = 0; idx < 4; idx++) begin
                exp_rst = (idx == THR_WARN_LOW || idx == THR_CRIT_LOW) ? '0 : '1;
                wb_access(1'b0, reg_addr_t'((ch << 2) | idx), '0, rdat);
                check_equal($sformatf("reset value ch%0d idx%0d", ch, idx), exp_rst, rdat);
            end
        end

        fd = $fopen("dv/alert_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open dv/alert_vectors.txt");
        end
        n = $fscanf(fd, " %c", kind);
        while (n == 1) begin
            case (kind)
                "#": n = $fgets(line, fd);
                "W": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    wb_access(1'b1, reg_addr_t'(a), sample_t'(b), rdat);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    wb_access(1'b0, reg_addr_t'(a), '0, rdat);
                    check_equal($sformatf("read back addr %0h", a), b, rdat);
                end
                "S": begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    send_sample(chan_t'(a), sample_t'(b), level_t'(c));
                end
                default: stop_with_error("unknown line kind in the vector file");
            endcase
            n = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);

        @(negedge clk);
        sample_valid = 1'b0;
        cnt = 0;
        while (exp_ch_q.size() > 0 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt = cnt + 1;
        end
        if (exp_ch_q.size() > 0) begin
            stop_with_error("results still missing when the drain wait ran out");
        end

        // Quiet window so a stray result would still be caught
        repeat (LATENCY + 2) @(negedge clk);

        // The vectors leave every channel normal, so the worst level has dropped back
        check_equal("final worst_level", LVL_NORMAL, worst_level);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* include/alert_settings.svh */
// Build-time sizes of the sensor alert monitor, included by the package, RTL and testbench
`ifndef ALERT_SETTINGS_SVH
`define ALERT_SETTINGS_SVH

// Number of monitored channels, a power of two from 2 to 8
`define ALERT_NUM_CH 4

// Sample and threshold width, shared with the Wishbone data bus
`define ALERT_DATA_W 16

// Channel number width, log2 of the channel count
`define ALERT_CH_W 2

// Wishbone word address: channel in the upper bits, threshold index in the low two
`define ALERT_ADDR_W (`ALERT_CH_W + 2)

`endif

/* source/alert_collector.sv */
// Merges the detector outputs into one result stream and tracks per-channel and worst levels
`timescale 1ns/1ns
`default_nettype none
`include "alert_settings.svh"

module alert_collector
    import alert_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`ALERT_NUM_CH-1:0]     det_valid,
    input  level_t [`ALERT_NUM_CH-1:0]   det_level,
    output logic                         result_valid,
    output chan_t                        result_channel,
    output level_t                       result_level,
    output level_t [`ALERT_NUM_CH-1:0]   alert_levels,
    output level_t                       worst_level
);

    logic                       any_valid;
    chan_t                      src_ch;
    level_t [`ALERT_NUM_CH-1:0] levels_next;
    level_t                     worst_next;

    assign any_valid = |det_valid;

    // Detectors share one latency, so at most one bit is set
    always_comb begin
        src_ch = '0;
        for (int i = 0; i < `ALERT_NUM_CH; i++) begin
            if (det_valid[i]) begin
                src_ch = chan_t'(i);
            end
        end
    end

    // Level table after this cycle's update, and its maximum
    always_comb begin
        levels_next = alert_levels;
        if (any_valid) begin
            levels_next[src_ch] = det_level[src_ch];
        end
        worst_next = LVL_NORMAL;
        for (int i = 0; i < `ALERT_NUM_CH; i++) begin
            if (levels_next[i] > worst_next) begin
                worst_next = levels_next[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
            alert_levels <= {`ALERT_NUM_CH{LVL_NORMAL}};
            worst_level  <= LVL_NORMAL;
        end else begin
            result_valid <= any_valid;
            alert_levels <= levels_next;
            worst_level  <= worst_next;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (any_valid) begin
            result_channel <= src_ch;
            result_level   <= det_level[src_ch];
        end
    end

endmodule

`default_nettype wire

/* source/alert_pkg.sv */
// Types shared by the sensor alert monitor blocks, imported by each module that needs them
`default_nettype none
`include "alert_settings.svh"

package alert_pkg;

    typedef logic [`ALERT_DATA_W-1:0] sample_t;
    typedef logic [`ALERT_CH_W-1:0]   chan_t;
    typedef logic [1:0]               level_t;
    typedef logic [`ALERT_ADDR_W-1:0] reg_addr_t;

    // Alert level codes, ordered so that a larger value is more severe
    localparam level_t LVL_NORMAL   = 2'd0;
    localparam level_t LVL_WARNING  = 2'd1;
    localparam level_t LVL_CRITICAL = 2'd2;

    // Threshold index within a channel, the low two address bits
    typedef enum logic [1:0] {
        THR_WARN_LOW  = 2'd0,
        THR_WARN_HIGH = 2'd1,
        THR_CRIT_LOW  = 2'd2,
        THR_CRIT_HIGH = 2'd3
    } thr_sel_e;

    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage

`default_nettype wire

/* source/range_detector.sv */
// Four-stage pipeline that classifies one channel's samples as normal, warning or critical
`timescale 1ns/1ns
`default_nettype none
`include "alert_settings.svh"

module range_detector
    import alert_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  sample_t in_data,
    input  sample_t warning_low,
    input  sample_t warning_high,
    input  sample_t critical_low,
    input  sample_t critical_high,
    output logic    out_valid,
    output level_t  out_level
);

    // Stage 1 sample and the thresholds in force when it entered
    logic    s1_valid;
    sample_t s1_data;
    sample_t s1_warn_lo;
    sample_t s1_warn_hi;
    sample_t s1_crit_lo;
    sample_t s1_crit_hi;

    // Stage 2 window compare flags
    logic s2_valid;
    logic s2_below_crit;
    logic s2_above_crit;
    logic s2_below_warn;
    logic s2_above_warn;

    // Stage 3 classification
    logic s3_valid;
    logic s3_crit;
    logic s3_warn;

    // Valid bits of all stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            out_valid <= s3_valid;
        end
    end

    // Input register
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_data    <= in_data;
            s1_warn_lo <= warning_low;
            s1_warn_hi <= warning_high;
            s1_crit_lo <= critical_low;
            s1_crit_hi <= critical_high;
        end
    end

    // Compare, a value equal to a threshold is inside the window
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_below_crit <= (s1_data < s1_crit_lo);
            s2_above_crit <= (s1_data > s1_crit_hi);
            s2_below_warn <= (s1_data < s1_warn_lo);
            s2_above_warn <= (s1_data > s1_warn_hi);
        end
    end

    // Classify, critical wins over warning
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            s3_crit <= s2_below_crit || s2_above_crit;
            s3_warn <= !(s2_below_crit || s2_above_crit) && (s2_below_warn || s2_above_warn);
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (s3_valid) begin
            out_level <= s3_crit ? LVL_CRITICAL : (s3_warn ? LVL_WARNING : LVL_NORMAL);
        end
    end

endmodule

`default_nettype wire

/* source/sample_router.sv */
// Registers each incoming sample and steers it to one channel's range detector
`timescale 1ns/1ns
`default_nettype none
`include "alert_settings.svh"

module sample_router
    import alert_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sample_valid,
    input  chan_t                    sample_channel,
    input  sample_t                  sample_data,
    output logic [`ALERT_NUM_CH-1:0] ch_valid,
    output sample_t                  ch_data
);

    logic [`ALERT_NUM_CH-1:0] valid_dec;

    // One-hot decode of the channel, all zero when no sample arrives
    always_comb begin
        valid_dec = '0;
        if (sample_valid) begin
            valid_dec[sample_channel] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ch_valid <= '0;
        end else begin
            ch_valid <= valid_dec;
        end
    end

    // Shared data register seen by every detector
    // only the detector with its valid set picks it up
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            ch_data <= sample_data;
        end
    end

endmodule

`default_nettype wire

/* source/sensor_alert_top.sv */
// Top level of the sensor alert monitor, wiring registers, router, detectors and collector
`timescale 1ns/1ns
`default_nettype none
`include "alert_settings.svh"

module sensor_alert_top
    import alert_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_valid,
    input  chan_t                      sample_channel,
    input  sample_t                    sample_data,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  reg_addr_t                  wb_adr,
    input  sample_t                    wb_dat_w,
    output sample_t                    wb_dat_r,
    output logic                       wb_ack,
    output logic                       result_valid,
    output chan_t                      result_channel,
    output level_t                     result_level,
    output level_t [`ALERT_NUM_CH-1:0] alert_levels,
    output level_t                     worst_level
);

    sample_t [`ALERT_NUM_CH-1:0] warning_low;
    sample_t [`ALERT_NUM_CH-1:0] warning_high;
    sample_t [`ALERT_NUM_CH-1:0] critical_low;
    sample_t [`ALERT_NUM_CH-1:0] critical_high;
    logic    [`ALERT_NUM_CH-1:0] ch_valid;
    sample_t                     ch_data;
    logic    [`ALERT_NUM_CH-1:0] det_valid;
    level_t  [`ALERT_NUM_CH-1:0] det_level;

    wb_threshold_regs i_regs (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .warning_low   (warning_low),
        .warning_high  (warning_high),
        .critical_low  (critical_low),
        .critical_high (critical_high)
    );

    sample_router i_router (
        .clk            (clk),
        .rst            (rst),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data),
        .ch_valid       (ch_valid),
        .ch_data        (ch_data)
    );

    // One detector per channel, all fed from the shared router register
    for (genvar g = 0; g < `ALERT_NUM_CH; g++) begin : g_det
        range_detector i_det (
            .clk           (clk),
            .rst           (rst),
            .in_valid      (ch_valid[g]),
            .in_data       (ch_data),
            .warning_low   (warning_low[g]),
            .warning_high  (warning_high[g]),
            .critical_low  (critical_low[g]),
            .critical_high (critical_high[g]),
            .out_valid     (det_valid[g]),
            .out_level     (det_level[g])
        );
    end

    alert_collector i_collector (
        .clk            (clk),
        .rst            (rst),
        .det_valid      (det_valid),
        .det_level      (det_level),
        .result_valid   (result_valid),
        .result_channel (result_channel),
        .result_level   (result_level),
        .alert_levels   (alert_levels),
        .worst_level    (worst_level)
    );

endmodule

`default_nettype wire

/* source/wb_threshold_regs.sv */
// Wishbone classic slave holding the four thresholds of every channel for the range detectors
`timescale 1ns/1ns
`default_nettype none
`include "alert_settings.svh"

module wb_threshold_regs
    import alert_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  reg_addr_t                    wb_adr,
    input  sample_t                      wb_dat_w,
    output sample_t                      wb_dat_r,
    output logic                         wb_ack,
    output sample_t [`ALERT_NUM_CH-1:0] warning_low,
    output sample_t [`ALERT_NUM_CH-1:0] warning_high,
    output sample_t [`ALERT_NUM_CH-1:0] critical_low,
    output sample_t [`ALERT_NUM_CH-1:0] critical_high
);

    wb_state_e state;
    chan_t     acc_ch;
    thr_sel_e  acc_sel;
    logic      acc_start;
    sample_t   rd_mux;

    // Address split into channel and threshold index
    assign acc_ch  = wb_adr[`ALERT_ADDR_W-1:2];
    assign acc_sel = thr_sel_e'(wb_adr[1:0]);

    // A new access starts only from idle, so ack lasts one cycle
    assign acc_start = wb_cyc && wb_stb && (state == WB_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (acc_start) begin
                        state <= WB_ACK;
                    end
                end
                WB_ACK: begin
                    state <= WB_IDLE;
                end
                default: begin
                    state <= WB_IDLE;
                end
            endcase
        end
    end

    assign wb_ack = (state == WB_ACK);

    // Threshold storage, reset to windows that let every sample through as normal
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            warning_low   <= '0;
            warning_high  <= '1;
            critical_low  <= '0;
            critical_high <= '1;
        end else if (acc_start && wb_we) begin
            case (acc_sel)
                THR_WARN_LOW:  warning_low[acc_ch]   <= wb_dat_w;
                THR_WARN_HIGH: warning_high[acc_ch]  <= wb_dat_w;
                THR_CRIT_LOW:  critical_low[acc_ch]  <= wb_dat_w;
                THR_CRIT_HIGH: critical_high[acc_ch] <= wb_dat_w;
                default: ;
            endcase
        end
    end

    // Read-back select
    always_comb begin
        rd_mux = warning_low[acc_ch];
        case (acc_sel)
            THR_WARN_LOW:  rd_mux = warning_low[acc_ch];
            THR_WARN_HIGH: rd_mux = warning_high[acc_ch];
            THR_CRIT_LOW:  rd_mux = critical_low[acc_ch];
            THR_CRIT_HIGH: rd_mux = critical_high[acc_ch];
            default:       rd_mux = warning_low[acc_ch];
        endcase
    end

    // Read data is captured with the edge that raises ack
    always_ff @(posedge clk) begin
        if (acc_start) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/alert_pkg.sv
source/wb_threshold_regs.sv
source/sample_router.sv
source/range_detector.sv
source/alert_collector.sv
source/sensor_alert_top.sv
dv/tb_sensor_alert.sv
